// ==== axi_slice_dc_master.f ====
+incdir+verilog
verilog/axi_chan_pkg.sv
verilog/token_ring_pkg.sv
verilog/token_ring_reader.sv
verilog/token_ring_writer.sv
verilog/stream_fifo_2.sv
verilog/axi_slice_dc_master.sv
testbench/tb_axi_slice_dc_master.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing -Mdir obj_dir
TOP       = tb_axi_slice_dc_master
FILELIST  = axi_slice_dc_master.f

.PHONY: simulate clean

# The grep status decides pass or fail
simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF "=== PASS ==="

clean:
	rm -rf obj_dir

// ==== testbench/tb_axi_slice_dc_master.sv ====
// Write-path slice testbench with far-side ring emulator, stimulus, checks and watchdog
`timescale 1ns/1ps
`include "axi_slice_dc_defines.svh"

module tb_axi_slice_dc_master
    import axi_chan_pkg::*;
    import token_ring_pkg::*;
();

    localparam int SLOT_W      = $clog2(`BUFFER_DEPTH);
    localparam int TOTAL_BEATS = 130;

    logic clk;
    logic reset = 1'b1;

    // Far side
    aw_payload_t aw_drive = '0;
    w_payload_t  w_drive  = '0;
    ring_t       aw_tok   = RING_RESET;
    ring_t       w_tok    = RING_RESET;
    ring_t       b_rp     = RING_RESET;
    ring_t       aw_rp;
    ring_t       w_rp;
    ring_t       b_tok;
    resp_t       b_resp;
    id_t         b_id;
    user_t       b_user;
    b_payload_t  b_far;
    aw_payload_t aw_slots [`BUFFER_DEPTH];
    w_payload_t  w_slots [`BUFFER_DEPTH];

    // Master side
    logic        aw_ready = 1'b1;
    logic        w_ready  = 1'b1;
    logic        b_valid  = 1'b0;
    b_payload_t  b_drive  = '0;
    logic        aw_valid;
    logic        w_valid;
    logic        b_ready;
    addr_t       aw_addr;
    id_t         aw_id;
    user_t       aw_user;
    user_t       w_user;
    len_t        aw_len;
    size_t       aw_size;
    burst_t      aw_burst;
    logic        aw_lock;
    cache_t      aw_cache;
    prot_t       aw_prot;
    region_t     aw_region;
    qos_t        aw_qos;
    data_t       w_data;
    strb_t       w_strb;
    logic        w_last;
    aw_payload_t aw_seen;
    w_payload_t  w_seen;

    // Test control and progress
    int          aw_target = 0;
    int          w_target  = 0;
    int          b_target  = 0;
    int          aw_sent   = 0;
    int          w_sent    = 0;
    int          aw_got    = 0;
    int          w_got     = 0;
    int          b_sent    = 0;
    int          b_shown   = 0;
    int          b_read    = 0;
    logic        aw_hold   = 1'b0;
    logic        b_stall   = 1'b1;
    logic [31:0] noise     = 32'd90;

    assign aw_seen = {aw_addr, aw_id, aw_user, aw_len, aw_size, aw_burst, aw_lock, aw_cache,
                      aw_prot, aw_region, aw_qos};
    assign w_seen  = {w_data, w_strb, w_user, w_last};
    assign b_far   = {b_resp, b_id, b_user};

    axi_slice_dc_master dut (
        .clk_i                      (clk),
        .reset_i                    (reset),
        .axi_slave_aw_addr_i        (aw_drive.addr),
        .axi_slave_aw_id_i          (aw_drive.id),
        .axi_slave_aw_user_i        (aw_drive.user),
        .axi_slave_aw_len_i         (aw_drive.len),
        .axi_slave_aw_size_i        (aw_drive.size),
        .axi_slave_aw_burst_i       (aw_drive.burst),
        .axi_slave_aw_lock_i        (aw_drive.lock),
        .axi_slave_aw_cache_i       (aw_drive.cache),
        .axi_slave_aw_prot_i        (aw_drive.prot),
        .axi_slave_aw_region_i      (aw_drive.region),
        .axi_slave_aw_qos_i         (aw_drive.qos),
        .axi_slave_aw_writetoken_i  (aw_tok),
        .axi_slave_aw_readpointer_o (aw_rp),
        .axi_slave_w_data_i         (w_drive.data),
        .axi_slave_w_strb_i         (w_drive.strb),
        .axi_slave_w_user_i         (w_drive.user),
        .axi_slave_w_last_i         (w_drive.last),
        .axi_slave_w_writetoken_i   (w_tok),
        .axi_slave_w_readpointer_o  (w_rp),
        .axi_slave_b_resp_o         (b_resp),
        .axi_slave_b_id_o           (b_id),
        .axi_slave_b_user_o         (b_user),
        .axi_slave_b_writetoken_o   (b_tok),
        .axi_slave_b_readpointer_i  (b_rp),
        .axi_master_aw_valid_o      (aw_valid),
        .axi_master_aw_addr_o       (aw_addr),
        .axi_master_aw_id_o         (aw_id),
        .axi_master_aw_user_o       (aw_user),
        .axi_master_aw_len_o        (aw_len),
        .axi_master_aw_size_o       (aw_size),
        .axi_master_aw_burst_o      (aw_burst),
        .axi_master_aw_lock_o       (aw_lock),
        .axi_master_aw_cache_o      (aw_cache),
        .axi_master_aw_prot_o       (aw_prot),
        .axi_master_aw_region_o     (aw_region),
        .axi_master_aw_qos_o        (aw_qos),
        .axi_master_aw_ready_i      (aw_ready),
        .axi_master_w_valid_o       (w_valid),
        .axi_master_w_data_o        (w_data),
        .axi_master_w_strb_o        (w_strb),
        .axi_master_w_user_o        (w_user),
        .axi_master_w_last_o        (w_last),
        .axi_master_w_ready_i       (w_ready),
        .axi_master_b_valid_i       (b_valid),
        .axi_master_b_resp_i        (b_drive.resp),
        .axi_master_b_id_i          (b_drive.id),
        .axi_master_b_user_i        (b_drive.user),
        .axi_master_b_ready_o       (b_ready)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Word idx of the sequence replayed from the seed every time
    function automatic logic [31:0] draw(input int idx);
        logic [31:0] state;
        state = 32'd90;
        repeat (idx + 1) state = xorshift(state);
        return state;
    endfunction

    function automatic aw_payload_t aw_ref(input int n);
        logic [95:0] bits;
        bits = {draw(3 * n), draw(3 * n + 1), draw(3 * n + 2)};
        return bits[$bits(aw_payload_t)-1:0];
    endfunction

    function automatic w_payload_t w_ref(input int n);
        logic [95:0] bits;
        w_payload_t  p;
        bits = {draw(400 + 3 * n), draw(401 + 3 * n), draw(402 + 3 * n)};
        p = bits[78:0];
        p.last = (n % 4 == 3);
        return p;
    endfunction

    function automatic b_payload_t b_ref(input int n);
        logic [31:0] r;
        r = draw(800 + n);
        return r[13:0];
    endfunction

    function automatic ring_t rotate(input ring_t r);
        return {r[`BUFFER_DEPTH-2:0], r[`BUFFER_DEPTH-1]};
    endfunction

    function automatic logic [SLOT_W-1:0] slot_of(input ring_t r);
        logic [SLOT_W-1:0] s;
        s = '0;
        for (int i = 0; i < `BUFFER_DEPTH; i++) begin
            if (r[i]) s = SLOT_W'(i);
        end
        return s;
    endfunction

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_aw(input string name, input aw_payload_t exp, input aw_payload_t got);
        if (got !== exp) begin
            $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_w(input string name, input w_payload_t exp, input w_payload_t got);
        if (got !== exp) begin
            $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_b(input string name, input b_payload_t exp, input b_payload_t got);
        if (got !== exp) begin
            $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_ring(input string name, input ring_t exp, input ring_t got);
        if (got !== exp) begin
            $display("ERR %0t %s expected %b got %b", $time, name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("ERR %0t %s expected %b got %b", $time, name, exp, got);
            abort_run();
        end
    endtask

    // Sample just after the rising edge once everything has settled
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Far side runs on the same clock and writes only while its ring is not full
    always @(negedge clk) begin
        if (aw_sent < aw_target && rotate(aw_tok) != aw_rp) begin
            aw_slots[slot_of(aw_tok)] = aw_ref(aw_sent);
            aw_tok = rotate(aw_tok);
            aw_sent++;
        end
        if (w_sent < w_target && rotate(w_tok) != w_rp) begin
            w_slots[slot_of(w_tok)] = w_ref(w_sent);
            w_tok = rotate(w_tok);
            w_sent++;
        end
        aw_drive = aw_slots[slot_of(aw_rp)];
        w_drive  = w_slots[slot_of(w_rp)];
        if (!b_stall && b_rp != b_tok) begin
            check_b("axi_slave_b", b_ref(b_read), b_far);
            b_read++;
            b_rp = rotate(b_rp);
        end
    end

    // Master side drives ready and B valid and holds a pending B beat until taken
    always @(negedge clk) begin
        noise = xorshift(noise);
        aw_ready = !aw_hold;
        w_ready = noise[0];
        if (!b_valid || b_sent != b_shown) begin
            b_shown = b_sent;
            b_valid = (b_sent < b_target) && noise[1];
            b_drive = b_ref(b_sent);
        end
    end

    always @(posedge clk) begin
        if (aw_valid && aw_ready) begin
            check_aw("axi_master_aw", aw_ref(aw_got), aw_seen);
            aw_got++;
        end
        if (w_valid && w_ready) begin
            check_w("axi_master_w", w_ref(w_got), w_seen);
            w_got++;
        end
        if (b_valid && b_ready) begin
            b_sent++;
        end
    end

    initial begin
        repeat (TOTAL_BEATS * `BUFFER_DEPTH * 10) @(posedge clk);
        $display("Timeout: beats stopped moving before all tests finished");
        abort_run();
    end

    initial begin
        repeat (4) @(negedge clk);
        reset = 1'b0;
        next_cycle();
        check_bit("axi_master_aw_valid_o", 1'b0, aw_valid);
        check_bit("axi_master_w_valid_o", 1'b0, w_valid);
        check_bit("axi_master_b_ready_o", 1'b1, b_ready);
        check_ring("axi_slave_aw_readpointer_o", RING_RESET, aw_rp);
        check_ring("axi_slave_w_readpointer_o", RING_RESET, w_rp);
        check_ring("axi_slave_b_writetoken_o", RING_RESET, b_tok);

        aw_target = 40;
        wait (aw_got == aw_target);
        w_target = 40;
        wait (w_got == w_target);

        // Master stalls AW until the full ring blocks the far side
        next_cycle();
        aw_hold = 1'b1;
        aw_target = 60;
        repeat (50) next_cycle();
        check_bit("axi_master_aw_valid_o", 1'b1, aw_valid);
        if (aw_sent - aw_got != `BUFFER_DEPTH - 1 + `FIFO_DEPTH) begin
            $display("Far-side AW writer not held back, %0d beats in flight", aw_sent - aw_got);
            abort_run();
        end
        aw_hold = 1'b0;
        wait (aw_got == aw_target);

        // Far B reader starts stalled
        next_cycle();
        b_target = 30;
        while (b_ready) next_cycle();
        repeat (4) next_cycle();
        check_bit("axi_master_b_ready_o", 1'b0, b_ready);
        if (b_sent - b_read != `BUFFER_DEPTH - 1) begin
            $display("B ring stopped at %0d unread responses", b_sent - b_read);
            abort_run();
        end
        b_stall = 1'b0;
        wait (b_read == b_target);

        repeat (10) next_cycle();
        check_bit("axi_master_aw_valid_o", 1'b0, aw_valid);
        check_bit("axi_master_w_valid_o", 1'b0, w_valid);
        check_ring("axi_slave_b_writetoken_o", b_rp, b_tok);
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== verilog/axi_slice_dc_master.sv ====
// Master-side write path of a dual-clock AXI4 slice: AW and W rings in, B ring out
`timescale 1ns/1ps

module axi_slice_dc_master import axi_chan_pkg::*; import token_ring_pkg::*; (
    input  logic    clk_i,
    input  logic    reset_i,

    // Far side write address
    input  addr_t   axi_slave_aw_addr_i,
    input  id_t     axi_slave_aw_id_i,
    input  user_t   axi_slave_aw_user_i,
    input  len_t    axi_slave_aw_len_i,
    input  size_t   axi_slave_aw_size_i,
    input  burst_t  axi_slave_aw_burst_i,
    input  logic    axi_slave_aw_lock_i,
    input  cache_t  axi_slave_aw_cache_i,
    input  prot_t   axi_slave_aw_prot_i,
    input  region_t axi_slave_aw_region_i,
    input  qos_t    axi_slave_aw_qos_i,
    input  ring_t   axi_slave_aw_writetoken_i,
    output ring_t   axi_slave_aw_readpointer_o,

    // Far side write data
    input  data_t   axi_slave_w_data_i,
    input  strb_t   axi_slave_w_strb_i,
    input  user_t   axi_slave_w_user_i,
    input  logic    axi_slave_w_last_i,
    input  ring_t   axi_slave_w_writetoken_i,
    output ring_t   axi_slave_w_readpointer_o,

    // Far side write response
    output resp_t   axi_slave_b_resp_o,
    output id_t     axi_slave_b_id_o,
    output user_t   axi_slave_b_user_o,
    output ring_t   axi_slave_b_writetoken_o,
    input  ring_t   axi_slave_b_readpointer_i,

    // Master write address
    output logic    axi_master_aw_valid_o,
    output addr_t   axi_master_aw_addr_o,
    output id_t     axi_master_aw_id_o,
    output user_t   axi_master_aw_user_o,
    output len_t    axi_master_aw_len_o,
    output size_t   axi_master_aw_size_o,
    output burst_t  axi_master_aw_burst_o,
    output logic    axi_master_aw_lock_o,
    output cache_t  axi_master_aw_cache_o,
    output prot_t   axi_master_aw_prot_o,
    output region_t axi_master_aw_region_o,
    output qos_t    axi_master_aw_qos_o,
    input  logic    axi_master_aw_ready_i,

    // Master write data
    output logic    axi_master_w_valid_o,
    output data_t   axi_master_w_data_o,
    output strb_t   axi_master_w_strb_o,
    output user_t   axi_master_w_user_o,
    output logic    axi_master_w_last_o,
    input  logic    axi_master_w_ready_i,

    // Master write response
    input  logic    axi_master_b_valid_i,
    input  resp_t   axi_master_b_resp_i,
    input  id_t     axi_master_b_id_i,
    input  user_t   axi_master_b_user_i,
    output logic    axi_master_b_ready_o
);

    aw_payload_t aw_async;
    aw_payload_t aw_ring;
    aw_payload_t aw_out;
    logic        aw_ring_valid;
    logic        aw_ring_ready;

    w_payload_t  w_async;
    w_payload_t  w_ring;
    w_payload_t  w_out;
    logic        w_ring_valid;
    logic        w_ring_ready;

    b_payload_t  b_in;
    b_payload_t  b_async;

    assign aw_async = '{
        addr:   axi_slave_aw_addr_i,
        id:     axi_slave_aw_id_i,
        user:   axi_slave_aw_user_i,
        len:    axi_slave_aw_len_i,
        size:   axi_slave_aw_size_i,
        burst:  axi_slave_aw_burst_i,
        lock:   axi_slave_aw_lock_i,
        cache:  axi_slave_aw_cache_i,
        prot:   axi_slave_aw_prot_i,
        region: axi_slave_aw_region_i,
        qos:    axi_slave_aw_qos_i
    };

    assign axi_master_aw_addr_o   = aw_out.addr;
    assign axi_master_aw_id_o     = aw_out.id;
    assign axi_master_aw_user_o   = aw_out.user;
    assign axi_master_aw_len_o    = aw_out.len;
    assign axi_master_aw_size_o   = aw_out.size;
    assign axi_master_aw_burst_o  = aw_out.burst;
    assign axi_master_aw_lock_o   = aw_out.lock;
    assign axi_master_aw_cache_o  = aw_out.cache;
    assign axi_master_aw_prot_o   = aw_out.prot;
    assign axi_master_aw_region_o = aw_out.region;
    assign axi_master_aw_qos_o    = aw_out.qos;

    assign w_async = '{
        data: axi_slave_w_data_i,
        strb: axi_slave_w_strb_i,
        user: axi_slave_w_user_i,
        last: axi_slave_w_last_i
    };

    assign axi_master_w_data_o = w_out.data;
    assign axi_master_w_strb_o = w_out.strb;
    assign axi_master_w_user_o = w_out.user;
    assign axi_master_w_last_o = w_out.last;

    assign b_in = '{
        resp: axi_master_b_resp_i,
        id:   axi_master_b_id_i,
        user: axi_master_b_user_i
    };

    assign axi_slave_b_resp_o = b_async.resp;
    assign axi_slave_b_id_o   = b_async.id;
    assign axi_slave_b_user_o = b_async.user;

    // AW channel
    token_ring_reader #(.payload_t(aw_payload_t)) aw_reader (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .write_token_i  (axi_slave_aw_writetoken_i),
        .data_async_i   (aw_async),
        .read_pointer_o (axi_slave_aw_readpointer_o),
        .valid_o        (aw_ring_valid),
        .ready_i        (aw_ring_ready),
        .data_o         (aw_ring)
    );

    stream_fifo_2 #(.payload_t(aw_payload_t)) aw_buffer (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .valid_i (aw_ring_valid),
        .ready_o (aw_ring_ready),
        .data_i  (aw_ring),
        .valid_o (axi_master_aw_valid_o),
        .ready_i (axi_master_aw_ready_i),
        .data_o  (aw_out)
    );

    // W channel
    token_ring_reader #(.payload_t(w_payload_t)) w_reader (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .write_token_i  (axi_slave_w_writetoken_i),
        .data_async_i   (w_async),
        .read_pointer_o (axi_slave_w_readpointer_o),
        .valid_o        (w_ring_valid),
        .ready_i        (w_ring_ready),
        .data_o         (w_ring)
    );

    stream_fifo_2 #(.payload_t(w_payload_t)) w_buffer (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .valid_i (w_ring_valid),
        .ready_o (w_ring_ready),
        .data_i  (w_ring),
        .valid_o (axi_master_w_valid_o),
        .ready_i (axi_master_w_ready_i),
        .data_o  (w_out)
    );

    // B channel goes straight into the ring
    token_ring_writer #(.payload_t(b_payload_t)) b_writer (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .valid_i        (axi_master_b_valid_i),
        .ready_o        (axi_master_b_ready_o),
        .data_i         (b_in),
        .write_token_o  (axi_slave_b_writetoken_o),
        .read_pointer_i (axi_slave_b_readpointer_i),
        .data_async_o   (b_async)
    );

endmodule

// ==== verilog/stream_fifo_2.sv ====
// Small valid/ready decoupling FIFO with registered output
`timescale 1ns/1ps
`include "axi_slice_dc_defines.svh"

module stream_fifo_2 #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     reset_i,

    input  logic     valid_i,
    output logic     ready_o,
    input  payload_t data_i,

    output logic     valid_o,
    input  logic     ready_i,
    output payload_t data_o
);

    localparam int IDX_W = $clog2(`FIFO_DEPTH);
    localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`FIFO_DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(`FIFO_DEPTH);

    payload_t         mem [`FIFO_DEPTH];
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign push = valid_i && ready_o;
    assign pop  = valid_o && ready_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_idx <= '0;
            rd_idx <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_idx <= (wr_idx == LAST_IDX) ? '0 : wr_idx + 1'b1;
            end
            if (pop) begin
                rd_idx <= (rd_idx == LAST_IDX) ? '0 : rd_idx + 1'b1;
            end
            // Simultaneous push and pop leave the count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_idx] <= data_i;
        end
    end

    assign ready_o = (count != FULL_CNT);
    assign valid_o = (count != '0);
    assign data_o  = mem[rd_idx];

endmodule

// ==== verilog/token_ring_writer.sv ====
// Local write half of a token ring, slots stored here for the far side to read
`timescale 1ns/1ps
`include "axi_slice_dc_defines.svh"

module token_ring_writer import token_ring_pkg::*; #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     reset_i,

    input  logic     valid_i,
    output logic     ready_o,
    input  payload_t data_i,

    output ring_t    write_token_o,
    input  ring_t    read_pointer_i,
    output payload_t data_async_o
);

    payload_t slots [`BUFFER_DEPTH];

    ring_t write_token;
    ring_t pointer_meta;
    ring_t pointer_sync;
    logic  full;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            write_token  <= RING_RESET;
            pointer_meta <= RING_RESET;
            pointer_sync <= RING_RESET;
        end else begin
            pointer_meta <= read_pointer_i;
            pointer_sync <= pointer_meta;
            if (valid_i && ready_o) begin
                write_token <= ring_advance(write_token);
            end
        end
    end

    // Store into the slot named by the current token
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < `BUFFER_DEPTH; i++) begin
            if (valid_i && ready_o && write_token[i]) begin
                slots[i] <= data_i;
            end
        end
    end

    // Stale pointer only makes us look fuller than we are
    assign full    = (ring_advance(write_token) == pointer_sync);
    assign ready_o = !full;

    assign write_token_o = write_token;

    // Raw far pointer, slot under it does not change while readable
    always_comb begin
        data_async_o = slots[0];
        for (int i = 1; i < `BUFFER_DEPTH; i++) begin
            if (read_pointer_i[i]) begin
                data_async_o = slots[i];
            end
        end
    end

endmodule

// ==== verilog/token_ring_reader.sv ====
// Local read half of a token ring, far-side writes out as a valid/ready stream
`timescale 1ns/1ps

module token_ring_reader import token_ring_pkg::*; #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     reset_i,

    input  ring_t    write_token_i,
    input  payload_t data_async_i,
    output ring_t    read_pointer_o,

    output logic     valid_o,
    input  logic     ready_i,
    output payload_t data_o
);

    ring_t token_meta;
    ring_t token_sync;
    ring_t read_pointer;

    // Far token crosses through two flops, pointer moves per accepted beat
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            token_meta   <= RING_RESET;
            token_sync   <= RING_RESET;
            read_pointer <= RING_RESET;
        end else begin
            token_meta <= write_token_i;
            token_sync <= token_meta;
            if (valid_o && ready_i) begin
                read_pointer <= ring_advance(read_pointer);
            end
        end
    end

    // Entry pending while the synchronized token is ahead of us
    assign valid_o = (token_sync != read_pointer);

    assign read_pointer_o = read_pointer;

    // Far side selects its slot with our registered pointer
    assign data_o = data_async_i;

endmodule

// ==== verilog/token_ring_pkg.sv ====
// Ring position type, its reset value and the token advance function
`include "axi_slice_dc_defines.svh"

package token_ring_pkg;

    // One-hot slot position shared by write tokens and read pointers.
    // A token advances by a left rotation. The ring is empty when the
    // write token equals the read pointer and full when the rotated write
    // token equals the read pointer, so it holds BUFFER_DEPTH-1 entries at most
    typedef logic [`BUFFER_DEPTH-1:0] ring_t;

    localparam ring_t RING_RESET = ring_t'(1);

    // Next slot in the ring
    function automatic ring_t ring_advance(input ring_t pos);
        return {pos[`BUFFER_DEPTH-2:0], pos[`BUFFER_DEPTH-1]};
    endfunction

endpackage

// ==== verilog/axi_chan_pkg.sv ====
// AXI field types and write-path payload structs for AW, W and B
`include "axi_slice_dc_defines.svh"

package axi_chan_pkg;

    typedef logic [`AXI_ADDR_WIDTH-1:0]   addr_t;
    typedef logic [`AXI_DATA_WIDTH-1:0]   data_t;
    typedef logic [`AXI_DATA_WIDTH/8-1:0] strb_t;
    typedef logic [`AXI_ID_WIDTH-1:0]     id_t;
    typedef logic [`AXI_USER_WIDTH-1:0]   user_t;
    typedef logic [7:0]                   len_t;
    typedef logic [2:0]                   size_t;
    typedef logic [1:0]                   burst_t;
    typedef logic [3:0]                   cache_t;
    typedef logic [2:0]                   prot_t;
    typedef logic [3:0]                   region_t;
    typedef logic [3:0]                   qos_t;
    typedef logic [1:0]                   resp_t;

    // Write address beat
    typedef struct packed {
        addr_t   addr;
        id_t     id;
        user_t   user;
        len_t    len;
        size_t   size;
        burst_t  burst;
        logic    lock;
        cache_t  cache;
        prot_t   prot;
        region_t region;
        qos_t    qos;
    } aw_payload_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
        user_t user;
        logic  last;
    } w_payload_t;

    typedef struct packed {
        resp_t resp;
        id_t   id;
        user_t user;
    } b_payload_t;

endpackage

// ==== verilog/axi_slice_dc_defines.svh ====
// AXI field widths, ring depth and decoupling buffer depth
`ifndef AXI_SLICE_DC_DEFINES_SVH
`define AXI_SLICE_DC_DEFINES_SVH

// AXI field widths
`define AXI_ADDR_WIDTH 32
`define AXI_DATA_WIDTH 64
`define AXI_USER_WIDTH 6
`define AXI_ID_WIDTH   6

// Ring slots per channel, also the token and pointer width
`define BUFFER_DEPTH   8

// Entries in the buffer behind each ring reader
`define FIFO_DEPTH     2

`endif
